// ==== verilog/rdma_pkg.sv ====
// Engine field widths, word field positions, request/command/ack structs
// and the flow control state enum
package rdma_pkg;

  // Engine field widths
  localparam int OPCODE_BITS = 5;
  localparam int PID_BITS = 6;
  localparam int DEST_BITS = 4;
  localparam int STRM_BITS = 2;
  localparam int QPN_BITS = 24;
  localparam int OFFS_BITS = 4;
  localparam int VADDR_BITS = 48;
  localparam int WIRE_VADDR_BITS = 64;
  localparam int LEN_BITS = 28;
  localparam int WIRE_LEN_BITS = 32;

  // Bits below this carry only the opcode
  localparam int META_BASE = 32;
  localparam int N_OUTSTANDING = 8;

  localparam int SQ_WORD_BITS = 256;
  // Command fields end at bit 145, word padded to a 32-bit multiple
  localparam int CMD_WORD_BITS = 160;
  localparam int ACK_WORD_BITS = 64;

  localparam logic MODE_RAW = 1'b1;

  // QPN holds pid low, vfid above, zero on top
  localparam int QPN_PID_POS = META_BASE;
  localparam int QPN_VFID_POS = META_BASE + PID_BITS;
  localparam int META_END = META_BASE + QPN_BITS;

  // Send word
  localparam int SQ_HOST_POS = META_END;
  localparam int SQ_LAST_POS = SQ_HOST_POS + 1;
  localparam int SQ_OFFS_POS = SQ_LAST_POS + 1;
  localparam int SQ_LVADDR_POS = SQ_OFFS_POS + OFFS_BITS;
  localparam int SQ_RVADDR_POS = SQ_LVADDR_POS + WIRE_VADDR_BITS;
  localparam int SQ_LEN_POS = SQ_RVADDR_POS + WIRE_VADDR_BITS;

  // Memory command word
  localparam int CMD_LAST_POS = META_END;
  localparam int CMD_VADDR_POS = CMD_LAST_POS + 1;
  localparam int CMD_DEST_POS = CMD_VADDR_POS + VADDR_BITS;
  localparam int CMD_STRM_POS = CMD_DEST_POS + DEST_BITS;
  localparam int CMD_LEN_POS = CMD_STRM_POS + STRM_BITS;
  localparam int CMD_ACTV_POS = CMD_LEN_POS + LEN_BITS;
  localparam int CMD_HOST_POS = CMD_ACTV_POS + 1;
  localparam int CMD_OFFS_POS = CMD_HOST_POS + 1;

  // Ack word
  localparam int ACK_HOST_POS = META_END;
  localparam int ACK_DEST_POS = ACK_HOST_POS + 1;
  localparam int ACK_STRM_POS = ACK_DEST_POS + DEST_BITS;
  localparam int ACK_LAST_POS = ACK_STRM_POS + STRM_BITS;

  localparam int CREDIT_BITS = $clog2(N_OUTSTANDING + 1);

  typedef logic [OPCODE_BITS-1:0] opcode_t;
  typedef logic [PID_BITS-1:0] pid_t;
  typedef logic [DEST_BITS-1:0] vfid_t;
  typedef logic [DEST_BITS-1:0] dest_t;
  typedef logic [STRM_BITS-1:0] strm_t;
  typedef logic [OFFS_BITS-1:0] offs_t;
  typedef logic [VADDR_BITS-1:0] vaddr_t;
  typedef logic [LEN_BITS-1:0] len_t;

  typedef logic [SQ_WORD_BITS-1:0] sq_word_t;
  typedef logic [CMD_WORD_BITS-1:0] cmd_word_t;
  typedef logic [ACK_WORD_BITS-1:0] ack_word_t;

  typedef logic [CREDIT_BITS-1:0] credit_t;
  localparam credit_t CREDIT_FULL = credit_t'(N_OUTSTANDING);

  // User send queue request
  typedef struct packed {
    opcode_t opcode;
    pid_t pid;
    vfid_t vfid;
    logic host;
    logic last;
    offs_t offs;
    vaddr_t lvaddr;
    vaddr_t rvaddr;
    len_t len;
  } sq_req_t;

  // Memory read or write request from the engine
  typedef struct packed {
    opcode_t opcode;
    logic mode;
    logic rdma;
    logic remote;
    pid_t pid;
    vfid_t vfid;
    logic last;
    vaddr_t vaddr;
    dest_t dest;
    strm_t strm;
    len_t len;
    logic actv;
    logic host;
    offs_t offs;
  } mem_req_t;

  // Completion
  typedef struct packed {
    opcode_t opcode;
    logic remote;
    pid_t pid;
    vfid_t vfid;
    logic host;
    dest_t dest;
    strm_t strm;
    logic last;
  } ack_t;

  typedef enum logic [1:0] {
    FLOW_IDLE,
    FLOW_HOLD,
    FLOW_STALL
  } flow_state_e;

endpackage

// ==== verilog/rdma_flow_ctrl.sv ====
// Send request holding register, outstanding credit counter
// and ack pass-through with credit return
`timescale 1ns/1ps

module rdma_flow_ctrl (
  input  logic              nclk,
  input  logic              arst_n,
  input  logic              sq_valid,
  output logic              sq_ready,
  input  rdma_pkg::sq_req_t sq_req,
  output logic              fc_sq_valid,
  input  logic              fc_sq_ready,
  output rdma_pkg::sq_req_t fc_sq_req,
  input  logic              unp_ack_valid,
  output logic              unp_ack_ready,
  input  rdma_pkg::ack_t    unp_ack,
  output logic              ack_valid,
  input  logic              ack_ready,
  output rdma_pkg::ack_t    ack
);

  import rdma_pkg::*;

  flow_state_e state;
  flow_state_e state_nxt;
  credit_t credit_cnt;
  credit_t credit_nxt;
  logic sq_fire;
  logic fc_fire;
  logic credit_take;
  logic credit_give;

  // Register full in HOLD only, STALL means empty with no credit left
  assign fc_sq_valid = (state == FLOW_HOLD);
  assign sq_ready = (state == FLOW_IDLE) ||
                    (state == FLOW_HOLD && fc_sq_ready && credit_cnt != CREDIT_FULL);

  assign sq_fire = sq_valid && sq_ready;
  assign fc_fire = fc_sq_valid && fc_sq_ready;

  // Acks go straight to the user
  assign ack_valid = unp_ack_valid;
  assign ack = unp_ack;
  assign unp_ack_ready = ack_ready;

  assign credit_take = sq_fire && sq_req.last;
  assign credit_give = ack_valid && ack_ready && ack.last;

  always_comb begin
    credit_nxt = credit_cnt;
    if (credit_take && !credit_give) begin
      credit_nxt = credit_cnt + credit_t'(1);
    end else if (credit_give && !credit_take && credit_cnt != '0) begin
      // Stray last acks with nothing outstanding are ignored
      credit_nxt = credit_cnt - credit_t'(1);
    end
  end

  always_comb begin
    if (sq_fire) begin
      state_nxt = FLOW_HOLD;
    end else if (state == FLOW_HOLD && !fc_fire) begin
      state_nxt = FLOW_HOLD;
    end else if (credit_nxt == CREDIT_FULL) begin
      state_nxt = FLOW_STALL;
    end else begin
      state_nxt = FLOW_IDLE;
    end
  end

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= FLOW_IDLE;
      credit_cnt <= '0;
    end else begin
      state <= state_nxt;
      credit_cnt <= credit_nxt;
    end
  end

  always_ff @(posedge nclk) begin
    if (sq_fire) begin
      fc_sq_req <= sq_req;
    end
  end

endmodule

// ==== verilog/sq_packer.sv ====
// Packs send requests into the engine metadata word, output registered
`timescale 1ns/1ps

module sq_packer (
  input  logic               nclk,
  input  logic               arst_n,
  input  logic               fc_sq_valid,
  output logic               fc_sq_ready,
  input  rdma_pkg::sq_req_t  fc_sq_req,
  output logic               stack_sq_valid,
  input  logic               stack_sq_ready,
  output rdma_pkg::sq_word_t stack_sq_word
);

  import rdma_pkg::*;

  sq_word_t sq_word_nxt;

  always_comb begin
    // Unused bits and QPN padding stay zero
    sq_word_nxt = '0;
    sq_word_nxt[0 +: OPCODE_BITS] = fc_sq_req.opcode;
    sq_word_nxt[QPN_PID_POS +: PID_BITS] = fc_sq_req.pid;
    sq_word_nxt[QPN_VFID_POS +: DEST_BITS] = fc_sq_req.vfid;
    sq_word_nxt[SQ_HOST_POS] = fc_sq_req.host;
    sq_word_nxt[SQ_LAST_POS] = fc_sq_req.last;
    sq_word_nxt[SQ_OFFS_POS +: OFFS_BITS] = fc_sq_req.offs;
    sq_word_nxt[SQ_LVADDR_POS +: WIRE_VADDR_BITS] = WIRE_VADDR_BITS'(fc_sq_req.lvaddr);
    sq_word_nxt[SQ_RVADDR_POS +: WIRE_VADDR_BITS] = WIRE_VADDR_BITS'(fc_sq_req.rvaddr);
    sq_word_nxt[SQ_LEN_POS +: WIRE_LEN_BITS] = WIRE_LEN_BITS'(fc_sq_req.len);
  end

  // Take a new request when empty or draining this cycle
  assign fc_sq_ready = !stack_sq_valid || stack_sq_ready;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      stack_sq_valid <= 1'b0;
    end else if (fc_sq_valid && fc_sq_ready) begin
      stack_sq_valid <= 1'b1;
    end else if (stack_sq_ready) begin
      stack_sq_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (fc_sq_valid && fc_sq_ready) begin
      stack_sq_word <= sq_word_nxt;
    end
  end

endmodule

// ==== verilog/ack_unpacker.sv ====
// Input register and field split for engine acknowledgement words
`timescale 1ns/1ps

module ack_unpacker (
  input  logic                nclk,
  input  logic                arst_n,
  input  logic                stack_ack_valid,
  output logic                stack_ack_ready,
  input  rdma_pkg::ack_word_t stack_ack_word,
  output logic                unp_ack_valid,
  input  logic                unp_ack_ready,
  output rdma_pkg::ack_t      unp_ack
);

  import rdma_pkg::*;

  ack_word_t ack_word_q;

  assign stack_ack_ready = !unp_ack_valid || unp_ack_ready;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      unp_ack_valid <= 1'b0;
    end else if (stack_ack_valid && stack_ack_ready) begin
      unp_ack_valid <= 1'b1;
    end else if (unp_ack_ready) begin
      unp_ack_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (stack_ack_valid && stack_ack_ready) begin
      ack_word_q <= stack_ack_word;
    end
  end

  always_comb begin
    unp_ack.opcode = ack_word_q[0 +: OPCODE_BITS];
    // Acks from the engine always complete remote operations
    unp_ack.remote = 1'b1;
    unp_ack.pid = ack_word_q[QPN_PID_POS +: PID_BITS];
    unp_ack.vfid = ack_word_q[QPN_VFID_POS +: DEST_BITS];
    unp_ack.host = ack_word_q[ACK_HOST_POS];
    unp_ack.dest = ack_word_q[ACK_DEST_POS +: DEST_BITS];
    unp_ack.strm = ack_word_q[ACK_STRM_POS +: STRM_BITS];
    unp_ack.last = ack_word_q[ACK_LAST_POS];
  end

endmodule

// ==== verilog/mem_cmd_unpacker.sv ====
// Input register and field split for one engine memory command stream
`timescale 1ns/1ps

module mem_cmd_unpacker (
  input  logic                nclk,
  input  logic                arst_n,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  rdma_pkg::cmd_word_t cmd_word,
  output logic                req_valid,
  input  logic                req_ready,
  output rdma_pkg::mem_req_t  req
);

  import rdma_pkg::*;

  cmd_word_t cmd_word_q;

  assign cmd_ready = !req_valid || req_ready;

  always_ff @(posedge nclk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      req_valid <= 1'b1;
    end else if (req_ready) begin
      req_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_word_q <= cmd_word;
    end
  end

  always_comb begin
    req.opcode = cmd_word_q[0 +: OPCODE_BITS];
    // Fixed fields for engine-issued memory traffic
    req.mode = MODE_RAW;
    req.rdma = 1'b1;
    req.remote = 1'b0;
    req.pid = cmd_word_q[QPN_PID_POS +: PID_BITS];
    req.vfid = cmd_word_q[QPN_VFID_POS +: DEST_BITS];
    req.last = cmd_word_q[CMD_LAST_POS];
    req.vaddr = cmd_word_q[CMD_VADDR_POS +: VADDR_BITS];
    req.dest = cmd_word_q[CMD_DEST_POS +: DEST_BITS];
    req.strm = cmd_word_q[CMD_STRM_POS +: STRM_BITS];
    req.len = cmd_word_q[CMD_LEN_POS +: LEN_BITS];
    req.actv = cmd_word_q[CMD_ACTV_POS];
    req.host = cmd_word_q[CMD_HOST_POS];
    req.offs = cmd_word_q[CMD_OFFS_POS +: OFFS_BITS];
  end

endmodule

// ==== verilog/rdma_shim_top.sv ====
// Command shim top level with flow control, send packer,
// ack unpacker and the read and write command unpackers
`timescale 1ns/1ps

module rdma_shim_top (
  input  logic                nclk,
  input  logic                arst_n,
  input  logic                sq_valid,
  output logic                sq_ready,
  input  rdma_pkg::sq_req_t   sq_req,
  output logic                stack_sq_valid,
  input  logic                stack_sq_ready,
  output rdma_pkg::sq_word_t  stack_sq_word,
  input  logic                stack_rd_cmd_valid,
  output logic                stack_rd_cmd_ready,
  input  rdma_pkg::cmd_word_t stack_rd_cmd_word,
  output logic                rd_req_valid,
  input  logic                rd_req_ready,
  output rdma_pkg::mem_req_t  rd_req,
  input  logic                stack_wr_cmd_valid,
  output logic                stack_wr_cmd_ready,
  input  rdma_pkg::cmd_word_t stack_wr_cmd_word,
  output logic                wr_req_valid,
  input  logic                wr_req_ready,
  output rdma_pkg::mem_req_t  wr_req,
  input  logic                stack_ack_valid,
  output logic                stack_ack_ready,
  input  rdma_pkg::ack_word_t stack_ack_word,
  output logic                ack_valid,
  input  logic                ack_ready,
  output rdma_pkg::ack_t      ack
);

  import rdma_pkg::*;

  // Flow control to packer
  logic fc_sq_valid;
  logic fc_sq_ready;
  sq_req_t fc_sq_req;

  // Unpacked acks into flow control
  logic unp_ack_valid;
  logic unp_ack_ready;
  ack_t unp_ack;

  rdma_flow_ctrl rdma_shim_flow_ctrl (
    .nclk          (nclk),
    .arst_n        (arst_n),
    .sq_valid      (sq_valid),
    .sq_ready      (sq_ready),
    .sq_req        (sq_req),
    .fc_sq_valid   (fc_sq_valid),
    .fc_sq_ready   (fc_sq_ready),
    .fc_sq_req     (fc_sq_req),
    .unp_ack_valid (unp_ack_valid),
    .unp_ack_ready (unp_ack_ready),
    .unp_ack       (unp_ack),
    .ack_valid     (ack_valid),
    .ack_ready     (ack_ready),
    .ack           (ack)
  );

  sq_packer sq_packer_inst (
    .nclk           (nclk),
    .arst_n         (arst_n),
    .fc_sq_valid    (fc_sq_valid),
    .fc_sq_ready    (fc_sq_ready),
    .fc_sq_req      (fc_sq_req),
    .stack_sq_valid (stack_sq_valid),
    .stack_sq_ready (stack_sq_ready),
    .stack_sq_word  (stack_sq_word)
  );

  ack_unpacker ack_unpacker_inst (
    .nclk            (nclk),
    .arst_n          (arst_n),
    .stack_ack_valid (stack_ack_valid),
    .stack_ack_ready (stack_ack_ready),
    .stack_ack_word  (stack_ack_word),
    .unp_ack_valid   (unp_ack_valid),
    .unp_ack_ready   (unp_ack_ready),
    .unp_ack         (unp_ack)
  );

  mem_cmd_unpacker rd_unpacker (
    .nclk      (nclk),
    .arst_n    (arst_n),
    .cmd_valid (stack_rd_cmd_valid),
    .cmd_ready (stack_rd_cmd_ready),
    .cmd_word  (stack_rd_cmd_word),
    .req_valid (rd_req_valid),
    .req_ready (rd_req_ready),
    .req       (rd_req)
  );

  mem_cmd_unpacker wr_unpacker (
    .nclk      (nclk),
    .arst_n    (arst_n),
    .cmd_valid (stack_wr_cmd_valid),
    .cmd_ready (stack_wr_cmd_ready),
    .cmd_word  (stack_wr_cmd_word),
    .req_valid (wr_req_valid),
    .req_ready (wr_req_ready),
    .req       (wr_req)
  );

endmodule

// ==== testbench/rdma_shim_chk.sv ====
// Bound assertions on the flow control handshakes and the credit count
`timescale 1ns/1ps

module rdma_shim_chk (
  input logic              nclk,
  input logic              arst_n,
  input logic              sq_valid,
  input logic              sq_ready,
  input rdma_pkg::sq_req_t sq_req,
  input logic              ack_valid,
  input logic              ack_ready,
  input rdma_pkg::ack_t    ack,
  input rdma_pkg::credit_t credit_cnt
);

  import rdma_pkg::*;

  // Number of failed assertions
  int fail_cnt;

  // Held items keep valid high and data stable
  sq_hold_a: assert property (@(posedge nclk) disable iff (!arst_n)
    sq_valid && !sq_ready |=> sq_valid && $stable(sq_req))
    else begin
      $error("send request dropped or changed while waiting");
      fail_cnt++;
    end

  ack_hold_a: assert property (@(posedge nclk) disable iff (!arst_n)
    ack_valid && !ack_ready |=> ack_valid && $stable(ack))
    else begin
      $error("ack dropped or changed while waiting");
      fail_cnt++;
    end

  credit_max_a: assert property (@(posedge nclk) disable iff (!arst_n)
    credit_cnt <= CREDIT_FULL)
    else begin
      $error("credit count above the outstanding limit");
      fail_cnt++;
    end

  full_stall_a: assert property (@(posedge nclk) disable iff (!arst_n)
    credit_cnt == CREDIT_FULL |-> !sq_ready)
    else begin
      $error("sq_ready high with all credit in use");
      fail_cnt++;
    end

endmodule

bind rdma_flow_ctrl rdma_shim_chk rdma_shim_chk_inst (
  .nclk        (nclk),
  .arst_n      (arst_n),
  .sq_valid    (sq_valid),
  .sq_ready    (sq_ready),
  .sq_req      (sq_req),
  .ack_valid   (ack_valid),
  .ack_ready   (ack_ready),
  .ack         (ack),
  .credit_cnt  (credit_cnt)
);

// ==== testbench/rdma_shim_monitor.sv ====
// Scoreboard with reference pack and unpack rules, expected queues
// per channel, hold checks and a credit model
`timescale 1ns/1ps

module rdma_shim_monitor (
  input  logic                nclk,
  input  logic                arst_n,
  input  logic                end_check,
  input  logic                sq_valid,
  input  logic                sq_ready,
  input  rdma_pkg::sq_req_t   sq_req,
  input  logic                stack_sq_valid,
  input  logic                stack_sq_ready,
  input  rdma_pkg::sq_word_t  stack_sq_word,
  input  logic                stack_rd_cmd_valid,
  input  logic                stack_rd_cmd_ready,
  input  rdma_pkg::cmd_word_t stack_rd_cmd_word,
  input  logic                rd_req_valid,
  input  logic                rd_req_ready,
  input  rdma_pkg::mem_req_t  rd_req,
  input  logic                stack_wr_cmd_valid,
  input  logic                stack_wr_cmd_ready,
  input  rdma_pkg::cmd_word_t stack_wr_cmd_word,
  input  logic                wr_req_valid,
  input  logic                wr_req_ready,
  input  rdma_pkg::mem_req_t  wr_req,
  input  logic                stack_ack_valid,
  input  logic                stack_ack_ready,
  input  rdma_pkg::ack_word_t stack_ack_word,
  input  logic                ack_valid,
  input  logic                ack_ready,
  input  rdma_pkg::ack_t      ack,
  output int                  err_cnt,
  output int                  pending
);

  import rdma_pkg::*;

  sq_word_t sq_exp[$];
  mem_req_t rd_exp[$];
  mem_req_t wr_exp[$];
  ack_t ack_exp[$];
  int sq_in, sq_out, rd_in, rd_out, wr_in, wr_out, ack_in, ack_out;
  int model_credit;
  int last_in;
  int last_out;
  int stall_cycles;
  bit end_done;
  bit sq_held, rd_held, wr_held, ack_held;
  logic [255:0] sq_prev, rd_prev, wr_prev, ack_prev;

  // Send word with QPN at 32 and 14 zero bits on top, addresses to 64 and len to 32
  function automatic sq_word_t pack_sq(input sq_req_t r);
    return {34'b0, 4'b0, r.len, 16'b0, r.rvaddr, 16'b0, r.lvaddr, r.offs, r.last,
            r.host, 14'b0, r.vfid, r.pid, 27'b0, r.opcode};
  endfunction

  function automatic mem_req_t unpack_cmd(input cmd_word_t w);
    mem_req_t r;
    r.opcode = w[4:0];
    r.mode = MODE_RAW;
    r.rdma = 1'b1;
    r.remote = 1'b0;
    r.pid = w[37:32];
    r.vfid = w[41:38];
    r.last = w[56];
    r.vaddr = w[104:57];
    r.dest = w[108:105];
    r.strm = w[110:109];
    r.len = w[138:111];
    r.actv = w[139];
    r.host = w[140];
    r.offs = w[144:141];
    return r;
  endfunction

  function automatic ack_t unpack_ack(input ack_word_t w);
    ack_t a;
    a.opcode = w[4:0];
    a.remote = 1'b1;
    a.pid = w[37:32];
    a.vfid = w[41:38];
    a.host = w[56];
    a.dest = w[60:57];
    a.strm = w[62:61];
    a.last = w[63];
    return a;
  endfunction

  task automatic compare_item(input string name, input logic [255:0] exp,
                              input logic [255:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_hold(input string name, input bit held, input logic valid,
                            input logic [255:0] prev, input logic [255:0] cur);
    if (held && (!valid || cur !== prev)) begin
      $display("Output %s was dropped or changed while held", name);
      err_cnt++;
    end
  endtask

  always @(posedge nclk) begin
    if (arst_n) begin
      check_hold("stack_sq_word", sq_held, stack_sq_valid, sq_prev, 256'(stack_sq_word));
      check_hold("rd_req", rd_held, rd_req_valid, rd_prev, 256'(rd_req));
      check_hold("wr_req", wr_held, wr_req_valid, wr_prev, 256'(wr_req));
      check_hold("ack", ack_held, ack_valid, ack_prev, 256'(ack));
      sq_held = stack_sq_valid && !stack_sq_ready;
      rd_held = rd_req_valid && !rd_req_ready;
      wr_held = wr_req_valid && !wr_req_ready;
      ack_held = ack_valid && !ack_ready;
      sq_prev = 256'(stack_sq_word);
      rd_prev = 256'(rd_req);
      wr_prev = 256'(wr_req);
      ack_prev = 256'(ack);

      if (sq_valid && sq_ready) begin
        sq_exp.push_back(pack_sq(sq_req));
        sq_in++;
      end
      if (stack_rd_cmd_valid && stack_rd_cmd_ready) begin
        rd_exp.push_back(unpack_cmd(stack_rd_cmd_word));
        rd_in++;
      end
      if (stack_wr_cmd_valid && stack_wr_cmd_ready) begin
        wr_exp.push_back(unpack_cmd(stack_wr_cmd_word));
        wr_in++;
      end
      if (stack_ack_valid && stack_ack_ready) begin
        ack_exp.push_back(unpack_ack(stack_ack_word));
        ack_in++;
      end

      if (stack_sq_valid && stack_sq_ready) begin
        sq_out++;
        if (sq_exp.size() == 0) begin
          $display("Send word appeared with no request pending");
          err_cnt++;
        end else begin
          compare_item("stack_sq_word", 256'(sq_exp.pop_front()), 256'(stack_sq_word));
        end
      end
      if (rd_req_valid && rd_req_ready) begin
        rd_out++;
        if (rd_exp.size() == 0) begin
          $display("Read request appeared with no command pending");
          err_cnt++;
        end else begin
          compare_item("rd_req", 256'(rd_exp.pop_front()), 256'(rd_req));
        end
      end
      if (wr_req_valid && wr_req_ready) begin
        wr_out++;
        if (wr_exp.size() == 0) begin
          $display("Write request appeared with no command pending");
          err_cnt++;
        end else begin
          compare_item("wr_req", 256'(wr_exp.pop_front()), 256'(wr_req));
        end
      end
      if (ack_valid && ack_ready) begin
        ack_out++;
        if (ack_exp.size() == 0) begin
          $display("Ack appeared with no ack word pending");
          err_cnt++;
        end else begin
          compare_item("ack", 256'(ack_exp.pop_front()), 256'(ack));
        end
      end

      // Credit model where a last ack with nothing outstanding returns nothing
      if (model_credit == N_OUTSTANDING && sq_ready) begin
        $display("sq_ready was high with all %0d credits in use", N_OUTSTANDING);
        err_cnt++;
      end
      if (model_credit == N_OUTSTANDING && sq_valid) begin
        stall_cycles++;
      end
      if (sq_valid && sq_ready && sq_req.last) begin
        last_in++;
      end
      if (ack_valid && ack_ready && ack.last) begin
        last_out++;
      end
      if ((sq_valid && sq_ready && sq_req.last) && !(ack_valid && ack_ready && ack.last)) begin
        model_credit++;
      end else if (!(sq_valid && sq_ready && sq_req.last) &&
                   (ack_valid && ack_ready && ack.last) && model_credit > 0) begin
        model_credit--;
      end
      if (last_in > N_OUTSTANDING + last_out) begin
        $display("Too many last requests accepted: %0d against %0d last acks",
                 last_in, last_out);
        err_cnt++;
      end

      if (end_check && !end_done) begin
        end_done = 1'b1;
        if (sq_in != sq_out || rd_in != rd_out || wr_in != wr_out || ack_in != ack_out) begin
          $display("Transfer counts in/out differ: sq %0d/%0d rd %0d/%0d wr %0d/%0d ack %0d/%0d",
                   sq_in, sq_out, rd_in, rd_out, wr_in, wr_out, ack_in, ack_out);
          err_cnt++;
        end
        if (stall_cycles == 0) begin
          $display("Send path never stalled on exhausted credit");
          err_cnt++;
        end
      end
      pending <= sq_exp.size() + rd_exp.size() + wr_exp.size() + ack_exp.size();
    end
  end

endmodule

// ==== testbench/tb_rdma_shim.sv ====
// Testbench top with clock, reset, random traffic on every channel,
// random output back-pressure, run timeout and the final report
`timescale 1ns/1ps

module tb_rdma_shim;

  import rdma_pkg::*;

  localparam int N_ITEMS = 200;
  localparam int TIMEOUT_CYCLES = 20 * N_ITEMS;

  logic nclk;
  logic arst_n;
  logic sq_valid;
  logic sq_ready;
  sq_req_t sq_req;
  logic stack_sq_valid;
  logic stack_sq_ready;
  sq_word_t stack_sq_word;
  logic stack_rd_cmd_valid;
  logic stack_rd_cmd_ready;
  cmd_word_t stack_rd_cmd_word;
  logic rd_req_valid;
  logic rd_req_ready;
  mem_req_t rd_req;
  logic stack_wr_cmd_valid;
  logic stack_wr_cmd_ready;
  cmd_word_t stack_wr_cmd_word;
  logic wr_req_valid;
  logic wr_req_ready;
  mem_req_t wr_req;
  logic stack_ack_valid;
  logic stack_ack_ready;
  ack_word_t stack_ack_word;
  logic ack_valid;
  logic ack_ready;
  ack_t ack;

  int seed;
  int cycle_cnt;
  int timeout_errs;
  int mon_errs;
  int assert_errs;
  int pending;
  logic end_check;
  bit ack_release;
  bit sq_done;

  rdma_shim_top rdma_shim_top_inst (.*);

  rdma_shim_monitor rdma_shim_monitor_inst (
    .err_cnt (mon_errs),
    .*
  );

  // Failures of the bound flow control assertions
  assign assert_errs = rdma_shim_top_inst.rdma_shim_flow_ctrl.rdma_shim_chk_inst.fail_cnt;

  initial nclk = 1'b0;
  always #20 nclk = ~nclk;

  // Random back-pressure on every output
  always @(posedge nclk) begin
    if (arst_n) begin
      stack_sq_ready <= ($random(seed) & 3) != 0;
      rd_req_ready <= ($random(seed) & 3) != 0;
      wr_req_ready <= ($random(seed) & 3) != 0;
      ack_ready <= ($random(seed) & 3) != 0;
    end
  end

  always @(posedge nclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      timeout_errs = timeout_errs + 1;
      $display("Run timed out after %0d cycles with traffic still stalled", cycle_cnt);
      $display("Errors: check=%0d assert=%0d timeout=%0d",
               mon_errs, assert_errs, timeout_errs);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic make_sq_req(output sq_req_t r);
    r.opcode = opcode_t'($random(seed));
    r.pid = pid_t'($random(seed));
    r.vfid = vfid_t'($random(seed));
    r.host = 1'($random(seed));
    r.last = ($random(seed) & 3) == 0;
    r.offs = offs_t'($random(seed));
    r.lvaddr = vaddr_t'({$random(seed), $random(seed)});
    r.rvaddr = vaddr_t'({$random(seed), $random(seed)});
    r.len = len_t'($random(seed));
  endtask

  task automatic send_sq(input sq_req_t r);
    sq_valid <= 1'b1;
    sq_req <= r;
    @(posedge nclk);
    while (!sq_ready) @(posedge nclk);
    sq_valid <= 1'b0;
  endtask

  task automatic send_rd_cmd(input cmd_word_t w);
    stack_rd_cmd_valid <= 1'b1;
    stack_rd_cmd_word <= w;
    @(posedge nclk);
    while (!stack_rd_cmd_ready) @(posedge nclk);
    stack_rd_cmd_valid <= 1'b0;
  endtask

  task automatic send_wr_cmd(input cmd_word_t w);
    stack_wr_cmd_valid <= 1'b1;
    stack_wr_cmd_word <= w;
    @(posedge nclk);
    while (!stack_wr_cmd_ready) @(posedge nclk);
    stack_wr_cmd_valid <= 1'b0;
  endtask

  task automatic send_ack(input ack_word_t w);
    stack_ack_valid <= 1'b1;
    stack_ack_word <= w;
    @(posedge nclk);
    while (!stack_ack_ready) @(posedge nclk);
    stack_ack_valid <= 1'b0;
  endtask

  task automatic run_sq_traffic();
    sq_req_t r;
    // Use up all credit while acks are held back
    for (int i = 0; i < N_OUTSTANDING; i++) begin
      make_sq_req(r);
      r.last = 1'b1;
      send_sq(r);
    end
    make_sq_req(r);
    r.last = 1'b1;
    sq_valid <= 1'b1;
    sq_req <= r;
    repeat (12) @(posedge nclk);
    ack_release = 1'b1;
    send_sq(r);
    for (int i = N_OUTSTANDING + 1; i < N_ITEMS; i++) begin
      repeat ($random(seed) & 3) @(posedge nclk);
      make_sq_req(r);
      send_sq(r);
    end
    sq_done = 1'b1;
  endtask

  task automatic run_cmd_traffic(input bit is_wr);
    cmd_word_t w;
    for (int i = 0; i < N_ITEMS; i++) begin
      repeat ($random(seed) & 3) @(posedge nclk);
      w = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      if (is_wr) begin
        send_wr_cmd(w);
      end else begin
        send_rd_cmd(w);
      end
    end
  endtask

  task automatic run_ack_traffic();
    ack_word_t w;
    int n;
    wait (ack_release);
    n = 0;
    // Bit 63 is the last flag and the first ack frees the stalled request
    while (n < N_ITEMS || !sq_done) begin
      w = {$random(seed), $random(seed)};
      if (n == 0 || n >= N_ITEMS) begin
        w[63] = 1'b1;
      end
      send_ack(w);
      n++;
      repeat ($random(seed) & 3) @(posedge nclk);
    end
  endtask

  initial begin
    seed = 26249;
    arst_n = 1'b0;
    sq_valid = 1'b0;
    sq_req = '0;
    stack_sq_ready = 1'b0;
    stack_rd_cmd_valid = 1'b0;
    stack_rd_cmd_word = '0;
    rd_req_ready = 1'b0;
    stack_wr_cmd_valid = 1'b0;
    stack_wr_cmd_word = '0;
    wr_req_ready = 1'b0;
    stack_ack_valid = 1'b0;
    stack_ack_word = '0;
    ack_ready = 1'b0;
    end_check = 1'b0;
    repeat (5) @(posedge nclk);
    arst_n <= 1'b1;
    @(posedge nclk);
    fork
      run_sq_traffic();
      run_cmd_traffic(1'b0);
      run_cmd_traffic(1'b1);
      run_ack_traffic();
    join
    // Drain what is still in the pipeline
    repeat (2) @(posedge nclk);
    while (pending != 0) @(posedge nclk);
    end_check <= 1'b1;
    repeat (2) @(posedge nclk);
    $display("Errors: check=%0d assert=%0d timeout=%0d",
             mon_errs, assert_errs, timeout_errs);
    if (mon_errs == 0 && assert_errs == 0 && timeout_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
verilog/rdma_pkg.sv
verilog/rdma_flow_ctrl.sv
verilog/sq_packer.sv
verilog/ack_unpacker.sv
verilog/mem_cmd_unpacker.sv
verilog/rdma_shim_top.sv
testbench/rdma_shim_chk.sv
testbench/rdma_shim_monitor.sv
testbench/tb_rdma_shim.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rdma_shim
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
